//--- Bender.yml
package:
  name: frontend

sources:
  - design/loader_pkg.sv
  - design/video_cfg_if.sv
  - design/cfg_regs.sv
  - design/download_unpack.sv
  - design/aspect_ratio.sv
  - design/frontend_top.sv
  - target: test
    files:
      - test/tb_frontend.sv

//--- design/aspect_ratio.sv
/*
 Aspect values for the scaler. The core ratio comes from the TV standard
 and the vertical crop; a nonzero aspect mode overrides it.
*/

`timescale 1ns/1ps

module aspect_ratio
	import loader_pkg::*;
(
	input  logic    clk_1x,
	input  logic    RESET,
	video_cfg_if.user cfg,
	output aspect_t video_arx,
	output aspect_t video_ary
);

	logic [11:0] core_x;
	logic [11:0] core_y;

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= AR_DEF_X;
			core_y <= AR_DEF_Y;
		end else if (cfg.blanks_off || cfg.clean_hdmi) begin
			// Full frame shown, plain 4:3
			core_x <= AR_DEF_X;
			core_y <= AR_DEF_Y;
		end else if (cfg.pal) begin
			case (cfg.crop)
				2'd0: begin core_x <= AR_PAL_C0_X; core_y <= AR_PAL_C0_Y; end
				2'd1: begin core_x <= AR_PAL_C1_X; core_y <= AR_PAL_C1_Y; end
				2'd2: begin core_x <= AR_PAL_C2_X; core_y <= AR_PAL_C2_Y; end
				default: ;
			endcase
		end else begin
			case (cfg.crop)
				2'd0: begin core_x <= AR_NTSC_C0_X; core_y <= AR_NTSC_C0_Y; end
				2'd1: begin core_x <= AR_NTSC_C1_X; core_y <= AR_NTSC_C1_Y; end
				2'd2: begin core_x <= AR_NTSC_C2_X; core_y <= AR_NTSC_C2_Y; end
				// Crop 3 holds the last ratio
				default: ;
			endcase
		end
	end

	// Mode 0 uses the core ratio, others pass a scaler preset
	assign video_arx = (cfg.ar_mode == 2'd0) ? {1'b0, core_x} :
		{11'd0, cfg.ar_mode - 2'd1};
	assign video_ary = (cfg.ar_mode == 2'd0) ? {1'b0, core_y} : '0;

endmodule

//--- design/cfg_regs.sv
/*
 Wishbone classic register block. Word 0 holds the video control fields,
 word 1 reports load status. Each access gets a single-cycle ack, followed
 by at least one idle cycle.
*/

`timescale 1ns/1ps

module cfg_regs
	import loader_pkg::*;
#(
	parameter wb_data_t CFG_RESET_VALUE = '0
) (
	input  logic     clk_1x,
	input  logic     RESET,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_addr_t wb_adr,
	input  wb_data_t wb_dat_i,
	output wb_data_t wb_dat_o,
	output logic     wb_ack,
	input  logic     cart_loaded,
	video_cfg_if.regs cfg
);

	logic [CTRL_BITS-1:0] ctrl_q;
	wb_data_t             rd_data;
	logic                 access;

	// New access only when ack is not already up
	assign access = wb_cyc && wb_stb && !wb_ack;

	// Read mux
	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_CTRL:   rd_data[CTRL_BITS-1:0] = ctrl_q;
			REG_STATUS: rd_data[0] = cart_loaded;
			default:    rd_data = '0;
		endcase
	end

	// ============================================================
	// Ack and control register
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			wb_ack <= 1'b0;
			ctrl_q <= CFG_RESET_VALUE[CTRL_BITS-1:0];
		end else begin
			wb_ack <= access;
			if (access && wb_we && wb_adr == REG_CTRL) begin
				ctrl_q <= wb_dat_i[CTRL_BITS-1:0];
			end
		end
	end

	// Read data captured with the ack
	always_ff @(posedge clk_1x) begin
		if (access) begin
			wb_dat_o <= rd_data;
		end
	end

	// Field split toward the video side
	assign cfg.pal        = ctrl_q[0];
	assign cfg.crop       = ctrl_q[2:1];
	assign cfg.ar_mode    = ctrl_q[4:3];
	assign cfg.blanks_off = ctrl_q[5];
	assign cfg.clean_hdmi = ctrl_q[6];

endmodule

//--- design/download_unpack.sv
/*
 Unpacks the host's 16-bit download stream. Boot-ROM data becomes
 byte-swapped 32-bit writes, the handheld image becomes 32-bit RAM writes
 with host back-pressure, and the end of a main cartridge load raises a
 ROM-copy start pulse.
*/

`timescale 1ns/1ps

module download_unpack
	import loader_pkg::*;
(
	input  logic         clk_1x,
	input  logic         RESET,
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_data_t  ioctl_dout,
	output logic         ioctl_wait,
	output pif_addr_t    pif_addr,
	output ram_word_t    pif_data,
	output logic         pif_wren,
	output ioctl_addr_t  ram_addr,
	output ram_word_t    ram_data,
	output logic         ram_req,
	input  logic         ram_ready,
	output logic         romcopy_start,
	output ioctl_addr_t  romcopy_size,
	output logic         cart_loaded
);

	logic pif_dl;
	logic n64_dl;
	logic gb_dl;
	logic download_q;
	logic wr_even;
	logic wr_odd;
	logic dl_end;

	// Address bit 1 picks the half of the 32-bit word
	assign wr_even = ioctl_wr && !ioctl_addr[1];
	assign wr_odd  = ioctl_wr && ioctl_addr[1];

	// Falling edge of the download while main cart is selected
	assign dl_end = download_q && !ioctl_download &&
		(ioctl_index[5:0] == 6'(IDX_N64));

	// ============================================================
	// Control state
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_dl        <= 1'b0;
			n64_dl        <= 1'b0;
			gb_dl         <= 1'b0;
			download_q    <= 1'b0;
			pif_wren      <= 1'b0;
			ram_req       <= 1'b0;
			ioctl_wait    <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			// Target flags, one cycle behind the host
			pif_dl     <= ioctl_download && (ioctl_index[5:0] == 6'(IDX_PIF));
			n64_dl     <= ioctl_download && (ioctl_index[5:0] == 6'(IDX_N64));
			gb_dl      <= ioctl_download && (ioctl_index[5:0] == 6'(IDX_GB));
			download_q <= ioctl_download;

			romcopy_start <= dl_end;
			pif_wren      <= pif_dl && wr_odd;
			ram_req       <= 1'b0;

			if (n64_dl) begin
				cart_loaded <= 1'b1;
			end

			// Host held off until the RAM takes the word
			if (gb_dl) begin
				if (wr_odd) begin
					ram_req    <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ============================================================
	// Data and address capture
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (pif_dl && wr_even) begin
			pif_data[31:16] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
			pif_addr        <= {ioctl_index[6], ioctl_addr[10:2]};
		end
		if (pif_dl && wr_odd) begin
			pif_data[15:0] <= {ioctl_dout[7:0], ioctl_dout[15:8]};
		end

		// Handheld words go low half first, no swap
		if (gb_dl && wr_even) begin
			ram_data[15:0] <= ioctl_dout;
			ram_addr       <= ioctl_addr + CARTGB_START;
		end
		if (gb_dl && wr_odd) begin
			ram_data[31:16] <= ioctl_dout;
		end

		if (dl_end) begin
			romcopy_size <= ioctl_addr;
		end
	end

endmodule

//--- design/frontend_top.sv
/*
 Top level of the board front end. Connects the register port, the
 download unpacker and the aspect generator to plain ports.
*/

`timescale 1ns/1ps

module frontend_top
	import loader_pkg::*;
#(
	parameter wb_data_t CFG_RESET_VALUE = '0
) (
	input  logic         clk_1x,
	input  logic         RESET,
	// Wishbone register port
	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  wb_addr_t     wb_adr,
	input  wb_data_t     wb_dat_i,
	output wb_data_t     wb_dat_o,
	output logic         wb_ack,
	// Host download
	input  logic         ioctl_download,
	input  ioctl_index_t ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_data_t  ioctl_dout,
	input  logic         ioctl_wr,
	output logic         ioctl_wait,
	// Boot ROM and RAM writes
	output pif_addr_t    pif_addr,
	output ram_word_t    pif_data,
	output logic         pif_wren,
	output ioctl_addr_t  ram_addr,
	output ram_word_t    ram_data,
	output logic         ram_req,
	input  logic         ram_ready,
	output logic         romcopy_start,
	output ioctl_addr_t  romcopy_size,
	// Scaler
	output aspect_t      video_arx,
	output aspect_t      video_ary
);

	logic cart_loaded;

	video_cfg_if cfg_if_i ();

	cfg_regs #(
		.CFG_RESET_VALUE(CFG_RESET_VALUE)
	) cfg_regs_i (
		.clk_1x, .RESET,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
		.cart_loaded,
		.cfg(cfg_if_i.regs)
	);

	download_unpack download_unpack_i (
		.clk_1x, .RESET,
		.ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wait,
		.pif_addr, .pif_data, .pif_wren,
		.ram_addr, .ram_data, .ram_req, .ram_ready,
		.romcopy_start, .romcopy_size,
		.cart_loaded
	);

	aspect_ratio aspect_ratio_i (
		.clk_1x, .RESET,
		.cfg(cfg_if_i.user),
		.video_arx, .video_ary
	);

endmodule

//--- design/loader_pkg.sv
/*
 Shared widths, download index codes, register offsets and aspect tables
 for the console board front end. Modules take these by wildcard import.
*/

package loader_pkg;

	// ============================================================
	// Vector types
	// ============================================================
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	typedef logic [7:0]  ioctl_index_t;
	typedef logic [31:0] ram_word_t;
	typedef logic [9:0]  pif_addr_t;
	typedef logic [12:0] aspect_t;
	typedef logic [1:0]  crop_t;
	typedef logic [1:0]  ar_mode_t;
	typedef logic [1:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// Download targets, low 6 index bits
	localparam int IDX_PIF = 0;
	localparam int IDX_N64 = 1;
	localparam int IDX_GB  = 2;

	// Handheld image sits 8 MiB into RAM
	localparam ioctl_addr_t CARTGB_START = 27'd8388608;

	// Register word addresses
	localparam wb_addr_t REG_CTRL   = 2'd0;
	localparam wb_addr_t REG_STATUS = 2'd1;
	localparam int       CTRL_BITS  = 7;

	// ============================================================
	// Aspect ratios per standard and crop
	// ============================================================
	localparam logic [11:0] AR_DEF_X     = 12'd4;
	localparam logic [11:0] AR_DEF_Y     = 12'd3;
	localparam logic [11:0] AR_PAL_C0_X  = 12'd512;
	localparam logic [11:0] AR_PAL_C0_Y  = 12'd387;
	localparam logic [11:0] AR_PAL_C1_X  = 12'd1024;
	localparam logic [11:0] AR_PAL_C1_Y  = 12'd731;
	localparam logic [11:0] AR_PAL_C2_X  = 12'd2048;
	localparam logic [11:0] AR_PAL_C2_Y  = 12'd1419;
	localparam logic [11:0] AR_NTSC_C0_X = 12'd512;
	localparam logic [11:0] AR_NTSC_C0_Y = 12'd381;
	localparam logic [11:0] AR_NTSC_C1_X = 12'd1280;
	localparam logic [11:0] AR_NTSC_C1_Y = 12'd889;
	localparam logic [11:0] AR_NTSC_C2_X = 12'd2560;
	localparam logic [11:0] AR_NTSC_C2_Y = 12'd1714;

endpackage

//--- design/video_cfg_if.sv
/*
 Video settings passed from the register block to the aspect generator.
 Plain level signals, no handshake.
*/

`timescale 1ns/1ps

interface video_cfg_if
	import loader_pkg::*;
();

	logic     pal;
	logic     blanks_off;
	logic     clean_hdmi;
	crop_t    crop;
	ar_mode_t ar_mode;

	// Register side drives
	modport regs (output pal, crop, ar_mode, blanks_off, clean_hdmi);

	// Video side only reads
	modport user (input pal, crop, ar_mode, blanks_off, clean_hdmi);

endinterface

//--- src.f
design/loader_pkg.sv
design/video_cfg_if.sv
design/cfg_regs.sv
design/download_unpack.sv
design/aspect_ratio.sv
design/frontend_top.sv
test/tb_frontend.sv

//--- test/tb_frontend.sv
/*
 Directed testbench for frontend_top. Drives the register port and the
 host download, answers RAM requests after a random delay and checks
 every output path against the expected values.
*/

`timescale 1ns/1ps

module tb_frontend
	import loader_pkg::*;
();

	logic         clk_1x, RESET, wb_cyc, wb_stb, wb_we, wb_ack;
	logic         ioctl_download, ioctl_wr, ioctl_wait, pif_wren;
	logic         ram_req, ram_ready, romcopy_start;
	wb_addr_t     wb_adr;
	wb_data_t     wb_dat_i, wb_dat_o;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr, ram_addr, romcopy_size;
	ioctl_data_t  ioctl_dout;
	pif_addr_t    pif_addr;
	ram_word_t    pif_data, ram_data;
	aspect_t      video_arx, video_ary;

	frontend_top #(.CFG_RESET_VALUE('0)) dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	// ============================================================
	// Checks
	// ============================================================
	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic abort_with(string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic show_mismatch(string name, logic [31:0] exp, logic [31:0] act);
		$display("** Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
		stop_run();
	endtask

	task automatic check_word(string name, ram_word_t exp, ram_word_t act);
		if (exp !== act) show_mismatch(name, exp, act);
	endtask
	task automatic check_addr(string name, ioctl_addr_t exp, ioctl_addr_t act);
		if (exp !== act) show_mismatch(name, exp, act);
	endtask
	task automatic check_aspect(string name, aspect_t exp, aspect_t act);
		if (exp !== act) show_mismatch(name, exp, act);
	endtask
	task automatic check_wb(string name, wb_data_t exp, wb_data_t act);
		if (exp !== act) show_mismatch(name, exp, act);
	endtask

	// ============================================================
	// Bus and host drivers
	// ============================================================
	task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
		output wb_data_t rdata);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = wdata;
		for (n = 0; !wb_ack; n++) begin
			if (n == 16) abort_with("No Wishbone ack within 16 cycles");
			@(negedge clk_1x);
		end
		rdata = wb_dat_o;
		// Cycle held one more clock so the idle gap after ack is exercised
		@(negedge clk_1x);
		if (wb_ack) abort_with("Wishbone ack lasted more than one cycle");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic write_halfword(ioctl_addr_t addr, ioctl_data_t data);
		int n;
		for (n = 0; ioctl_wait; n++) begin
			if (n == 32) abort_with("Host held off by ioctl_wait for too long");
			@(negedge clk_1x);
		end
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
	endtask

	task automatic start_download(ioctl_index_t idx);
		ioctl_index = idx;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_1x);
	endtask

	// One ready pulse per request, 1 to 8 cycles later
	task automatic answer_ram();
		forever begin
			@(negedge clk_1x);
			if (ram_req) begin
				repeat ($urandom_range(1, 8)) @(negedge clk_1x);
				ram_ready <= 1'b1;
				@(negedge clk_1x);
				ram_ready <= 1'b0;
			end
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_reset();
		wb_data_t rd;
		wb_access(1'b0, 2'd0, '0, rd);
		check_wb("reset ctrl", 32'd0, rd);
		wb_access(1'b0, 2'd1, '0, rd);
		check_wb("reset status", 32'd0, rd);
		check_aspect("reset arx", 13'd512, video_arx);
		check_aspect("reset ary", 13'd381, video_ary);
	endtask

	task automatic test_regs();
		wb_data_t rd;
		wb_data_t wdata;
		for (int i = 0; i < 6; i++) begin
			wdata = $urandom();
			wb_access(1'b1, 2'd0, wdata, rd);
			wb_access(1'b0, 2'd0, '0, rd);
			check_wb("regs ctrl readback", wdata & 32'h7F, rd);
		end
		wb_access(1'b0, 2'd2, '0, rd);
		check_wb("regs word 2", 32'd0, rd);
	endtask

	task automatic test_boot(ioctl_index_t idx, ioctl_addr_t base);
		ioctl_addr_t a;
		ioctl_data_t d0, d1;
		start_download(idx);
		for (int i = 0; i < 4; i++) begin
			a = base + 27'(4 * i);
			d0 = ioctl_data_t'($urandom());
			d1 = ioctl_data_t'($urandom());
			write_halfword(a, d0);
			write_halfword(a + 27'd2, d1);
			if (!pif_wren) abort_with("pif_wren did not pulse after the odd halfword");
			check_word("boot data", {d0[7:0], d0[15:8], d1[7:0], d1[15:8]}, pif_data);
			check_addr("boot addr", ioctl_addr_t'({idx[6], a[10:2]}), ioctl_addr_t'(pif_addr));
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic test_handheld();
		ioctl_addr_t a;
		ioctl_data_t d0, d1;
		int n;
		start_download(8'd2);
		for (int i = 0; i < 5; i++) begin
			a = 27'(4 * i + 16);
			d0 = ioctl_data_t'($urandom());
			d1 = ioctl_data_t'($urandom());
			write_halfword(a, d0);
			write_halfword(a + 27'd2, d1);
			if (!ram_req) abort_with("ram_req did not pulse after the odd halfword");
			check_addr("handheld addr", a + 27'd8388608, ram_addr);
			check_word("handheld data", {d1, d0}, ram_data);
			for (n = 0; !ram_ready; n++) begin
				if (!ioctl_wait) abort_with("ioctl_wait dropped before ram_ready");
				if (n == 16) abort_with("No ram_ready seen for a request");
				@(negedge clk_1x);
			end
			if (ioctl_wait) abort_with("ioctl_wait still high after ram_ready");
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic test_cart();
		wb_data_t rd;
		start_download(8'd1);
		for (int i = 0; i < 4; i++) write_halfword(27'(2 * i), ioctl_data_t'($urandom()));
		ioctl_download = 1'b0;
		@(negedge clk_1x);
		if (!romcopy_start) abort_with("romcopy_start did not pulse at end of download");
		check_addr("cart romcopy size", 27'd6, romcopy_size);
		@(negedge clk_1x);
		if (romcopy_start) abort_with("romcopy_start lasted more than one cycle");
		wb_access(1'b0, 2'd1, '0, rd);
		check_wb("cart status", 32'd1, rd);
	endtask

	task automatic check_ratio(string name, wb_data_t ctrl, aspect_t x, aspect_t y);
		wb_data_t rd;
		wb_access(1'b1, 2'd0, ctrl, rd);
		repeat (2) @(negedge clk_1x);
		check_aspect(name, x, video_arx);
		check_aspect(name, y, video_ary);
	endtask

	task automatic test_aspect();
		// Rows are NTSC then PAL, columns crop 0 to 2
		aspect_t tx [2][3] = '{'{512, 1280, 2560}, '{512, 1024, 2048}};
		aspect_t ty [2][3] = '{'{381, 889, 1714}, '{387, 731, 1419}};
		for (int p = 0; p < 2; p++) begin
			for (int c = 0; c < 3; c++) begin
				check_ratio("aspect table", wb_data_t'(p | (c << 1)), tx[p][c], ty[p][c]);
			end
		end
		check_ratio("aspect blanks_off", 32'h23, 13'd4, 13'd3);
		check_ratio("aspect clean_hdmi", 32'h41, 13'd4, 13'd3);
		for (int m = 1; m < 4; m++) begin
			check_ratio("aspect mode", wb_data_t'(m << 3), aspect_t'(m - 1), 13'd0);
		end
	endtask

	initial begin
		void'($urandom(32'h5055_42bd));
		RESET = 1'b0;
		{wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_i} = '0;
		{ioctl_download, ioctl_wr, ioctl_index, ioctl_addr, ioctl_dout} = '0;
		ram_ready = 1'b0;
		fork
			answer_ram();
		join_none
		repeat (8) @(negedge clk_1x);
		RESET = 1'b1;
		repeat (2) @(negedge clk_1x);
		test_reset();
		test_regs();
		test_boot(8'd0, 27'h3F0);
		test_boot(8'd64, 27'h7E8);
		test_handheld();
		test_cart();
		test_aspect();
		$display("All tests passed!");
		$finish;
	end

	// Tests need a few thousand cycles at most
	initial begin
		repeat (20000) @(posedge clk_1x);
		abort_with("Timeout: tests did not finish within 20000 cycles");
	end

endmodule
